/* bench/display_checker.sv */
// Display bus and video assertions
`timescale 1ns/10ps
`default_nettype none

module display_checker (
    input wire                        clk,
    input wire                        rst,
    input wire                        cyc,
    input wire                        stb,
    input wire                        ack,
    input wire                        hblnk,
    input wire                        vblnk,
    input wire [vga_pkg::RGB_W-1:0]   rgb
);

    // ack answers a request seen on the edge before
    ack_has_request: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(cyc && stb))
        else $error("ack raised without cyc and stb");

    ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
        ack |=> !ack)
        else $error("ack held for more than one cycle");

    black_in_blanking: assert property (@(posedge clk) disable iff (rst)
        (hblnk || vblnk) |-> (rgb == '0))
        else $error("rgb not black during blanking");

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
// Testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;  // released just after the edge, like the bus stimulus
    end

endmodule

`default_nettype wire

/* bench/tb_game_display.sv */
// Game display testbench
`timescale 1ns/10ps
`default_nettype none

module tb_game_display;

    localparam int FRAME_CYCLES = vga_pkg::HOR_TOTAL * vga_pkg::VER_TOTAL;
    localparam int MAX_CYCLES   = 6 * FRAME_CYCLES + 1000;  // tests span about 5.5 frames
    localparam int MAX_PRINTS   = 30;

    // caption letters, 50 rows tall from row 260
    localparam byte CAPTION [8]  = '{"T", "A", "R", "T", "G", "A", "M", "E"};
    localparam int  LETTER_X [8] = '{255, 300, 340, 375, 435, 475, 515, 565};
    localparam int  LETTER_Y     = 260;

    logic                             clk, rst;
    logic                             cyc, stb, we;
    logic [1:0]                       adr;
    logic [screen_pkg::WB_DATA_W-1:0] dat_w, dat_r;
    logic                             ack;
    logic [vga_pkg::COUNT_W-1:0]      hcount, vcount;
    logic                             hsync, vsync, hblnk, vblnk;
    logic [vga_pkg::RGB_W-1:0]        rgb;

    int                        err_cnt, test_cnt, test_fail, cycles, frames_seen;
    logic                      check_en, have_prev;
    logic                      exp_mode, exp_pending;
    logic [vga_pkg::RGB_W-1:0] exp_bg;
    int                        prev_h, prev_v;
    logic [31:0]               rand_state;

    tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(5)) u_clock (.clk(clk), .rst(rst));

    game_display_top dut (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack),
        .hcount(hcount), .vcount(vcount), .hsync(hsync), .vsync(vsync),
        .hblnk(hblnk), .vblnk(vblnk), .rgb(rgb)
    );

    bind game_display_top display_checker u_display_checker (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .ack(ack),
        .hblnk(hblnk), .vblnk(vblnk), .rgb(rgb)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic in_box(input int dx, input int dy, input int x0, input int x1,
                                    input int y0, input int y1);
        return dx >= x0 && dx < x1 && dy >= y0 && dy < y1;
    endfunction

    // strokes relative to the letter's top left corner
    function automatic logic letter_hit(input byte ch, input int dx, input int dy);
        case (ch)
            "T": return in_box(dx, dy, 0, 40, 0, 10) || in_box(dx, dy, 15, 25, 10, 50);
            "A": return in_box(dx, dy, 0, 10, 10, 50) || in_box(dx, dy, 20, 30, 10, 50) ||
                        in_box(dx, dy, 10, 20, 0, 10) || in_box(dx, dy, 10, 20, 20, 30);
            "R": return in_box(dx, dy, 0, 10, 0, 50) || in_box(dx, dy, 10, 20, 0, 10) ||
                        in_box(dx, dy, 20, 30, 10, 30) || in_box(dx, dy, 10, 30, 20, 30) ||
                        in_box(dx, dy, 15, 25, 30, 40) || in_box(dx, dy, 20, 30, 40, 50);
            "G": return in_box(dx, dy, 0, 30, 0, 10) || in_box(dx, dy, 0, 10, 10, 50) ||
                        in_box(dx, dy, 10, 30, 40, 50) || in_box(dx, dy, 20, 30, 20, 50);
            "M": return in_box(dx, dy, 0, 10, 0, 50) || in_box(dx, dy, 30, 40, 0, 50) ||
                        in_box(dx, dy, 10, 15, 10, 20) || in_box(dx, dy, 25, 30, 10, 20) ||
                        in_box(dx, dy, 15, 25, 20, 30);
            "E": return in_box(dx, dy, 0, 10, 0, 50) || in_box(dx, dy, 10, 40, 0, 10) ||
                        in_box(dx, dy, 10, 40, 20, 30) || in_box(dx, dy, 10, 40, 40, 50);
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic caption_hit(input int h, input int v);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < 8; i++) begin
            if (letter_hit(CAPTION[i], h - LETTER_X[i], v - LETTER_Y)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic logic [vga_pkg::RGB_W-1:0] start_ref(input int h, input int v,
                                                            input logic [11:0] bg);
        if (h >= vga_pkg::HOR_PIXELS || v >= vga_pkg::VER_PIXELS) return 12'h000;
        if (v >= 250 && v <= 319 && h >= 200 && h <= 599) return 12'hff0;  // title block
        return bg;
    endfunction

    function automatic logic [vga_pkg::RGB_W-1:0] finish_ref(input int h, input int v);
        if (h >= vga_pkg::HOR_PIXELS || v >= vga_pkg::VER_PIXELS) return 12'h000;
        if (v == 0) return 12'hff0;
        if (v == vga_pkg::VER_PIXELS - 1) return 12'hf00;
        if (h == 0) return 12'h0f0;
        if (h == vga_pkg::HOR_PIXELS - 1) return 12'h00f;
        if (v >= 251 && v <= 319 && h >= 161 && h <= 649) begin
            return caption_hit(h, v) ? 12'h000 : 12'hff0;
        end
        return 12'h0f0;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            if (err_cnt <= MAX_PRINTS) begin
                $display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, exp);
            end
            if (err_cnt == MAX_PRINTS) begin
                $display("print limit reached, further mismatches are only counted");
            end
        end
    endtask

    task automatic bus_cycle(input logic write, input logic [1:0] addr,
                             input logic [15:0] wdata, output logic [15:0] rdata);
        int waited;
        @(posedge clk);
        #1;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        dat_w = wdata;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!ack && waited < 8);
        if (!ack) begin
            err_cnt++;
            $display("no Wishbone acknowledge for address %0d", addr);
        end
        rdata = dat_r;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
    endtask

    task automatic wb_write(input logic [1:0] addr, input logic [15:0] wdata);
        logic [15:0] unused;
        bus_cycle(1'b1, addr, wdata, unused);
    endtask

    task automatic wb_read(input logic [1:0] addr, output logic [15:0] rdata);
        bus_cycle(1'b0, addr, 16'h0000, rdata);
    endtask

    task automatic wait_line(input int line);
        do begin
            @(negedge clk);
        end while (!(hcount == 0 && vcount == line));
    endtask

    // frames_seen moves on the falling edge, so look at it on the rising one
    task automatic wait_frame_start();
        int start;
        start = frames_seen;
        do begin
            @(posedge clk);
        end while (frames_seen == start);
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            test_fail++;
            $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
        end
    endtask

    // output pixels are stable at the falling edge
    always @(negedge clk) begin : compare_pixels
        int nh, nv;
        if (check_en) begin
            if (hcount == 0 && vcount == 0) begin
                frames_seen++;
                exp_mode = exp_pending;  // first pixel under the new mode
            end
            if (have_prev) begin
                nh = (prev_h == vga_pkg::HOR_TOTAL - 1) ? 0 : prev_h + 1;
                nv = prev_v;
                if (nh == 0) begin
                    nv = (prev_v == vga_pkg::VER_TOTAL - 1) ? 0 : prev_v + 1;
                end
                check_value("hcount", hcount, nh);
                check_value("vcount", vcount, nv);
            end
            check_value("hblnk", hblnk, hcount >= vga_pkg::HOR_PIXELS);
            check_value("vblnk", vblnk, vcount >= vga_pkg::VER_PIXELS);
            check_value("hsync", hsync, hcount >= vga_pkg::HOR_SYNC_START &&
                        hcount < vga_pkg::HOR_SYNC_START + vga_pkg::HOR_SYNC_TIME);
            check_value("vsync", vsync, vcount >= vga_pkg::VER_SYNC_START &&
                        vcount < vga_pkg::VER_SYNC_START + vga_pkg::VER_SYNC_TIME);
            if (exp_mode == screen_pkg::MODE_FINISH) begin
                check_value("finish rgb", rgb, finish_ref(hcount, vcount));
            end else begin
                check_value("start rgb", rgb, start_ref(hcount, vcount, exp_bg));
            end
            prev_h    = hcount;
            prev_v    = vcount;
            have_prev = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, tests did not finish", MAX_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        logic [15:0] rd, cnt0, cnt1, step;
        int          f0, f1, e0;
        cyc         = 1'b0;
        stb         = 1'b0;
        we          = 1'b0;
        adr         = 2'd0;
        dat_w       = '0;
        err_cnt     = 0;
        test_cnt    = 0;
        test_fail   = 0;
        cycles      = 0;
        frames_seen = 0;
        check_en    = 1'b0;
        have_prev   = 1'b0;
        exp_mode    = screen_pkg::MODE_START;
        exp_pending = screen_pkg::MODE_START;
        exp_bg      = screen_pkg::RESET_START_BG;
        rand_state  = 32'h9e91_caef;

        wait (rst == 1'b0);
        e0 = err_cnt;
        check_value("hcount after reset", hcount, 0);
        check_value("vcount after reset", vcount, 0);
        check_value("syncs after reset", {hsync, vsync, hblnk, vblnk}, 0);
        check_value("rgb after reset", rgb, 0);
        wb_read(screen_pkg::ADDR_MODE, rd);
        check_value("mode register", rd, screen_pkg::MODE_START);
        wb_read(screen_pkg::ADDR_START_BG, rd);
        check_value("start_bg register", rd, 12'h00f);
        wb_read(screen_pkg::ADDR_FRAME_CNT, rd);
        check_value("frame counter", rd, 0);
        check_en = 1'b1;
        report_test("reset values", e0);

        // first frame, from the first valid output pixels on
        e0 = err_cnt;
        wait_frame_start();
        report_test("video timing", e0);

        e0 = err_cnt;
        wait_line(610);  // blanking, black whatever the background
        rand_state = xorshift32(rand_state);
        wb_write(screen_pkg::ADDR_START_BG, {4'h0, rand_state[11:0]});
        exp_bg = rand_state[11:0];
        wait_frame_start();
        wait_frame_start();
        report_test("start screen", e0);

        e0 = err_cnt;
        wait_line(300);
        wb_read(screen_pkg::ADDR_FRAME_CNT, cnt0);  // baseline for the frame count test
        f0 = frames_seen;
        wb_write(screen_pkg::ADDR_MODE, {15'h0, screen_pkg::MODE_FINISH});
        exp_pending = screen_pkg::MODE_FINISH;
        wb_read(screen_pkg::ADDR_MODE, rd);
        check_value("mode register", rd, screen_pkg::MODE_FINISH);
        wait_frame_start();
        wait_frame_start();
        report_test("finish screen", e0);

        e0 = err_cnt;
        wait_line(300);
        wb_read(screen_pkg::ADDR_FRAME_CNT, cnt1);
        f1 = frames_seen;
        step = cnt1 - cnt0;
        check_value("frames observed", f1 - f0, 2);
        check_value("frame counter step", step, f1 - f0);
        wb_write(screen_pkg::ADDR_FRAME_CNT, 16'h5a5a);
        wb_read(screen_pkg::ADDR_FRAME_CNT, rd);
        check_value("frame counter after write", rd, cnt1);
        wb_read(2'd3, rd);
        check_value("unused address", rd, 0);
        report_test("frame counter", e0);

        $display("tests: %0d, failed: %0d, mismatches: %0d", test_cnt, test_fail, err_cnt);
        if (test_fail == 0 && err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/finish_screen.sv */
// Finish screen painter
`timescale 1ns/10ps
`default_nettype none

module finish_screen #(
    parameter int H_ACTIVE = vga_pkg::HOR_PIXELS,
    parameter int V_ACTIVE = vga_pkg::VER_PIXELS
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire  [vga_pkg::COUNT_W-1:0]  tim_hcount,
    input  wire  [vga_pkg::COUNT_W-1:0]  tim_vcount,
    input  wire                          tim_hsync,
    input  wire                          tim_vsync,
    input  wire                          tim_hblnk,
    input  wire                          tim_vblnk,
    output logic [vga_pkg::COUNT_W-1:0]  hcount,
    output logic [vga_pkg::COUNT_W-1:0]  vcount,
    output logic                         hsync,
    output logic                         vsync,
    output logic                         hblnk,
    output logic                         vblnk,
    output logic [vga_pkg::RGB_W-1:0]    rgb
);

    // caption window, only fits at 800x600
    localparam int CAP_TOP    = 251;
    localparam int CAP_BOTTOM = 319;
    localparam int CAP_LEFT   = 161;
    localparam int CAP_RIGHT  = 649;

    // glyph strokes as {x0, x1, y0, y1}, upper bounds exclusive
    localparam int unsigned NUM_BOXES = 32;
    localparam int unsigned BOXES [NUM_BOXES][4] = '{
        '{255, 295, 260, 270}, '{270, 280, 270, 310},                          // T
        '{300, 310, 270, 310}, '{320, 330, 270, 310},                          // A
        '{310, 320, 260, 270}, '{310, 320, 280, 290},
        '{340, 350, 260, 310}, '{350, 360, 260, 270}, '{360, 370, 270, 290},   // R
        '{350, 370, 280, 290}, '{355, 365, 290, 300}, '{360, 370, 300, 310},
        '{375, 415, 260, 270}, '{390, 400, 270, 310},                          // T
        '{435, 465, 260, 270}, '{435, 445, 270, 310}, '{445, 465, 300, 310},   // G
        '{455, 465, 280, 290}, '{455, 465, 290, 310},
        '{475, 485, 270, 310}, '{495, 505, 270, 310},                          // A
        '{485, 495, 260, 270}, '{485, 495, 280, 290},
        '{515, 525, 260, 310}, '{545, 555, 260, 310}, '{525, 530, 270, 280},   // M
        '{540, 545, 270, 280}, '{530, 540, 280, 290},
        '{565, 575, 260, 310}, '{575, 605, 260, 270},                          // E
        '{575, 605, 280, 290}, '{575, 605, 300, 310}
    };

    logic [vga_pkg::RGB_W-1:0] rgb_nxt;

    function automatic logic glyph_hit(input logic [vga_pkg::COUNT_W-1:0] x,
                                       input logic [vga_pkg::COUNT_W-1:0] y);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < NUM_BOXES; i++) begin
            if (x >= BOXES[i][0] && x < BOXES[i][1] && y >= BOXES[i][2] && y < BOXES[i][3]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    always_comb begin
        if (tim_hblnk || tim_vblnk) begin
            rgb_nxt = screen_pkg::COLOUR_BLACK;
        end else if (tim_vcount == 0) begin
            rgb_nxt = screen_pkg::COLOUR_YELLOW;  // top border
        end else if (tim_vcount == V_ACTIVE - 1) begin
            rgb_nxt = screen_pkg::COLOUR_RED;     // bottom border
        end else if (tim_hcount == 0) begin
            rgb_nxt = screen_pkg::COLOUR_GREEN;   // left border
        end else if (tim_hcount == H_ACTIVE - 1) begin
            rgb_nxt = screen_pkg::COLOUR_BLUE;    // right border
        end else if (tim_vcount >= CAP_TOP && tim_vcount <= CAP_BOTTOM &&
                     tim_hcount >= CAP_LEFT && tim_hcount <= CAP_RIGHT) begin
            rgb_nxt = glyph_hit(tim_hcount, tim_vcount) ? screen_pkg::COLOUR_BLACK
                                                        : screen_pkg::COLOUR_YELLOW;
        end else begin
            rgb_nxt = screen_pkg::COLOUR_GREEN;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
            rgb    <= '0;
        end else begin
            hcount <= tim_hcount;
            vcount <= tim_vcount;
            hsync  <= tim_hsync;
            vsync  <= tim_vsync;
            hblnk  <= tim_hblnk;
            vblnk  <= tim_vblnk;
            rgb    <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

/* logic/game_display_top.sv */
// Game display top level
`timescale 1ns/10ps
`default_nettype none

module game_display_top #(
    parameter int H_ACTIVE     = vga_pkg::HOR_PIXELS,
    parameter int H_TOTAL      = vga_pkg::HOR_TOTAL,
    parameter int H_SYNC_START = vga_pkg::HOR_SYNC_START,
    parameter int H_SYNC_LEN   = vga_pkg::HOR_SYNC_TIME,
    parameter int V_ACTIVE     = vga_pkg::VER_PIXELS,
    parameter int V_TOTAL      = vga_pkg::VER_TOTAL,
    parameter int V_SYNC_START = vga_pkg::VER_SYNC_START,
    parameter int V_SYNC_LEN   = vga_pkg::VER_SYNC_TIME
) (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               cyc,
    input  wire                               stb,
    input  wire                               we,
    input  wire  [1:0]                        adr,
    input  wire  [screen_pkg::WB_DATA_W-1:0]  dat_w,
    output logic [screen_pkg::WB_DATA_W-1:0]  dat_r,
    output logic                              ack,
    output logic [vga_pkg::COUNT_W-1:0]       hcount,
    output logic [vga_pkg::COUNT_W-1:0]       vcount,
    output logic                              hsync,
    output logic                              vsync,
    output logic                              hblnk,
    output logic                              vblnk,
    output logic [vga_pkg::RGB_W-1:0]         rgb
);

    logic [vga_pkg::COUNT_W-1:0] tim_hcount, tim_vcount;
    logic                        tim_hsync, tim_vsync, tim_hblnk, tim_vblnk;
    logic                        frame_start;
    logic                        active_mode;
    logic [vga_pkg::RGB_W-1:0]   start_bg;

    logic [vga_pkg::COUNT_W-1:0] start_hcount, start_vcount;
    logic                        start_hsync, start_vsync, start_hblnk, start_vblnk;
    logic [vga_pkg::RGB_W-1:0]   start_rgb;

    logic [vga_pkg::COUNT_W-1:0] finish_hcount, finish_vcount;
    logic                        finish_hsync, finish_vsync, finish_hblnk, finish_vblnk;
    logic [vga_pkg::RGB_W-1:0]   finish_rgb;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .H_SYNC_START(H_SYNC_START),
        .H_SYNC_LEN(H_SYNC_LEN), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
        .V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN)
    ) u_vga_timing (
        .clk, .rst,
        .hcount(tim_hcount), .vcount(tim_vcount),
        .hsync(tim_hsync), .vsync(tim_vsync), .hblnk(tim_hblnk), .vblnk(tim_vblnk),
        .frame_start
    );

    screen_ctrl_wb u_screen_ctrl_wb (
        .clk, .rst, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
        .frame_start, .active_mode, .start_bg
    );

    start_screen #(.H_ACTIVE(H_ACTIVE)) u_start_screen (
        .clk, .rst,
        .tim_hcount, .tim_vcount, .tim_hsync, .tim_vsync, .tim_hblnk, .tim_vblnk,
        .start_bg,
        .hcount(start_hcount), .vcount(start_vcount),
        .hsync(start_hsync), .vsync(start_vsync), .hblnk(start_hblnk), .vblnk(start_vblnk),
        .rgb(start_rgb)
    );

    finish_screen #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_finish_screen (
        .clk, .rst,
        .tim_hcount, .tim_vcount, .tim_hsync, .tim_vsync, .tim_hblnk, .tim_vblnk,
        .hcount(finish_hcount), .vcount(finish_vcount),
        .hsync(finish_hsync), .vsync(finish_vsync),
        .hblnk(finish_hblnk), .vblnk(finish_vblnk),
        .rgb(finish_rgb)
    );

    screen_select u_screen_select (
        .clk, .rst, .active_mode,
        .start_hcount, .start_vcount, .start_hsync, .start_vsync,
        .start_hblnk, .start_vblnk, .start_rgb,
        .finish_hcount, .finish_vcount, .finish_hsync, .finish_vsync,
        .finish_hblnk, .finish_vblnk, .finish_rgb,
        .hcount, .vcount, .hsync, .vsync, .hblnk, .vblnk, .rgb
    );

endmodule

`default_nettype wire

/* logic/screen_ctrl_wb.sv */
// Screen control register slave
`timescale 1ns/10ps
`default_nettype none

module screen_ctrl_wb (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  cyc,
    input  wire                                  stb,
    input  wire                                  we,
    input  wire  [1:0]                           adr,
    input  wire  [screen_pkg::WB_DATA_W-1:0]     dat_w,
    output logic [screen_pkg::WB_DATA_W-1:0]     dat_r,
    output logic                                 ack,
    input  wire                                  frame_start,
    output logic                                 active_mode,
    output logic [vga_pkg::RGB_W-1:0]            start_bg
);

    logic                              mode;       // pending, applied at frame start
    logic [screen_pkg::WB_DATA_W-1:0]  frame_cnt;
    logic [screen_pkg::WB_DATA_W-1:0]  rd_data;
    logic                              req;

    assign req = cyc && stb && !ack;  // new cycle, not yet answered

    always_comb begin
        rd_data = '0;  // unused addresses read zero
        case (adr)
            screen_pkg::ADDR_MODE:      rd_data[0] = mode;
            screen_pkg::ADDR_START_BG:  rd_data[vga_pkg::RGB_W-1:0] = start_bg;
            screen_pkg::ADDR_FRAME_CNT: rd_data = frame_cnt;
            default:                    rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack         <= 1'b0;
            mode        <= screen_pkg::MODE_START;
            active_mode <= screen_pkg::MODE_START;
            start_bg    <= screen_pkg::RESET_START_BG;
            frame_cnt   <= '0;
        end else begin
            ack <= req;
            if (req && we) begin
                case (adr)
                    screen_pkg::ADDR_MODE:     mode <= dat_w[0];
                    screen_pkg::ADDR_START_BG: start_bg <= dat_w[vga_pkg::RGB_W-1:0];
                    default:                   ;  // frame counter is read only
                endcase
            end
            // mode swaps only between frames so a frame never tears
            if (frame_start) begin
                active_mode <= mode;
                frame_cnt   <= frame_cnt + 1'b1;  // wraps at 16 bits
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            dat_r <= rd_data;  // valid together with ack
        end
    end

endmodule

`default_nettype wire

/* logic/screen_pkg.sv */
// Screen control definitions
`default_nettype none

package screen_pkg;

    // screen modes
    localparam logic MODE_START  = 1'b0;
    localparam logic MODE_FINISH = 1'b1;

    // register word addresses
    localparam logic [1:0] ADDR_MODE      = 2'd0;
    localparam logic [1:0] ADDR_START_BG  = 2'd1;
    localparam logic [1:0] ADDR_FRAME_CNT = 2'd2;

    localparam int WB_DATA_W = 16;

    // fixed palette
    localparam logic [vga_pkg::RGB_W-1:0] COLOUR_BLACK  = 12'h000;
    localparam logic [vga_pkg::RGB_W-1:0] COLOUR_YELLOW = 12'hff0;
    localparam logic [vga_pkg::RGB_W-1:0] COLOUR_RED    = 12'hf00;
    localparam logic [vga_pkg::RGB_W-1:0] COLOUR_GREEN  = 12'h0f0;
    localparam logic [vga_pkg::RGB_W-1:0] COLOUR_BLUE   = 12'h00f;

    localparam logic [vga_pkg::RGB_W-1:0] RESET_START_BG = COLOUR_BLUE;

endpackage

`default_nettype wire

/* logic/screen_select.sv */
// Screen selection stage
`timescale 1ns/10ps
`default_nettype none

module screen_select (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          active_mode,
    input  wire  [vga_pkg::COUNT_W-1:0]  start_hcount,
    input  wire  [vga_pkg::COUNT_W-1:0]  start_vcount,
    input  wire                          start_hsync,
    input  wire                          start_vsync,
    input  wire                          start_hblnk,
    input  wire                          start_vblnk,
    input  wire  [vga_pkg::RGB_W-1:0]    start_rgb,
    input  wire  [vga_pkg::COUNT_W-1:0]  finish_hcount,
    input  wire  [vga_pkg::COUNT_W-1:0]  finish_vcount,
    input  wire                          finish_hsync,
    input  wire                          finish_vsync,
    input  wire                          finish_hblnk,
    input  wire                          finish_vblnk,
    input  wire  [vga_pkg::RGB_W-1:0]    finish_rgb,
    output logic [vga_pkg::COUNT_W-1:0]  hcount,
    output logic [vga_pkg::COUNT_W-1:0]  vcount,
    output logic                         hsync,
    output logic                         vsync,
    output logic                         hblnk,
    output logic                         vblnk,
    output logic [vga_pkg::RGB_W-1:0]    rgb
);

    // active_mode turns over just as pixel 0,0 arrives from the screens
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
            rgb    <= '0;
        end else if (active_mode == screen_pkg::MODE_FINISH) begin
            hcount <= finish_hcount;
            vcount <= finish_vcount;
            hsync  <= finish_hsync;
            vsync  <= finish_vsync;
            hblnk  <= finish_hblnk;
            vblnk  <= finish_vblnk;
            rgb    <= finish_rgb;
        end else begin
            hcount <= start_hcount;
            vcount <= start_vcount;
            hsync  <= start_hsync;
            vsync  <= start_vsync;
            hblnk  <= start_hblnk;
            vblnk  <= start_vblnk;
            rgb    <= start_rgb;
        end
    end

endmodule

`default_nettype wire

/* logic/start_screen.sv */
// Start screen painter
`timescale 1ns/10ps
`default_nettype none

module start_screen #(
    parameter int H_ACTIVE = vga_pkg::HOR_PIXELS
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire  [vga_pkg::COUNT_W-1:0]  tim_hcount,
    input  wire  [vga_pkg::COUNT_W-1:0]  tim_vcount,
    input  wire                          tim_hsync,
    input  wire                          tim_vsync,
    input  wire                          tim_hblnk,
    input  wire                          tim_vblnk,
    input  wire  [vga_pkg::RGB_W-1:0]    start_bg,
    output logic [vga_pkg::COUNT_W-1:0]  hcount,
    output logic [vga_pkg::COUNT_W-1:0]  vcount,
    output logic                         hsync,
    output logic                         vsync,
    output logic                         hblnk,
    output logic                         vblnk,
    output logic [vga_pkg::RGB_W-1:0]    rgb
);

    // title block centred across the middle half of the line
    localparam int TITLE_TOP    = 250;
    localparam int TITLE_BOTTOM = 319;
    localparam int TITLE_LEFT   = H_ACTIVE / 4;
    localparam int TITLE_RIGHT  = H_ACTIVE - H_ACTIVE / 4 - 1;

    logic [vga_pkg::RGB_W-1:0] rgb_nxt;

    always_comb begin
        if (tim_hblnk || tim_vblnk) begin
            rgb_nxt = screen_pkg::COLOUR_BLACK;
        end else if (tim_vcount >= TITLE_TOP && tim_vcount <= TITLE_BOTTOM &&
                     tim_hcount >= TITLE_LEFT && tim_hcount <= TITLE_RIGHT) begin
            rgb_nxt = screen_pkg::COLOUR_YELLOW;
        end else begin
            rgb_nxt = start_bg;  // host programmed
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
            rgb    <= '0;
        end else begin
            hcount <= tim_hcount;
            vcount <= tim_vcount;
            hsync  <= tim_hsync;
            vsync  <= tim_vsync;
            hblnk  <= tim_hblnk;
            vblnk  <= tim_vblnk;
            rgb    <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

/* logic/vga_pkg.sv */
// VGA timing constants
`default_nettype none

package vga_pkg;

    // 800x600 at 40 MHz pixel clock
    localparam int HOR_PIXELS     = 800;  // visible pixels per line
    localparam int HOR_TOTAL      = 1056;
    localparam int HOR_SYNC_START = 840;
    localparam int HOR_SYNC_TIME  = 128;

    localparam int VER_PIXELS     = 600;  // visible lines per frame
    localparam int VER_TOTAL      = 628;
    localparam int VER_SYNC_START = 601;
    localparam int VER_SYNC_TIME  = 4;

    localparam int COUNT_W        = 11;   // enough for 1056
    localparam int RGB_W          = 12;   // 4 bits per channel

endpackage

`default_nettype wire

/* logic/vga_timing.sv */
// VGA timing generator
`timescale 1ns/10ps
`default_nettype none

module vga_timing #(
    parameter int H_ACTIVE     = vga_pkg::HOR_PIXELS,
    parameter int H_TOTAL      = vga_pkg::HOR_TOTAL,
    parameter int H_SYNC_START = vga_pkg::HOR_SYNC_START,
    parameter int H_SYNC_LEN   = vga_pkg::HOR_SYNC_TIME,
    parameter int V_ACTIVE     = vga_pkg::VER_PIXELS,
    parameter int V_TOTAL      = vga_pkg::VER_TOTAL,
    parameter int V_SYNC_START = vga_pkg::VER_SYNC_START,
    parameter int V_SYNC_LEN   = vga_pkg::VER_SYNC_TIME
) (
    input  wire                          clk,
    input  wire                          rst,
    output logic [vga_pkg::COUNT_W-1:0]  hcount,
    output logic [vga_pkg::COUNT_W-1:0]  vcount,
    output logic                         hsync,
    output logic                         vsync,
    output logic                         hblnk,
    output logic                         vblnk,
    output logic                         frame_start
);

    logic [vga_pkg::COUNT_W-1:0] h_nxt;
    logic [vga_pkg::COUNT_W-1:0] v_nxt;

    always_comb begin
        h_nxt = hcount + 1'b1;
        v_nxt = vcount;
        if (hcount == H_TOTAL - 1) begin  // end of line
            h_nxt = '0;
            v_nxt = (vcount == V_TOTAL - 1) ? '0 : vcount + 1'b1;
        end
    end

    // flags come from the next count so they line up with the counters
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount      <= '0;
            vcount      <= '0;
            hsync       <= 1'b0;
            vsync       <= 1'b0;
            hblnk       <= 1'b0;
            vblnk       <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            hcount      <= h_nxt;
            vcount      <= v_nxt;
            hblnk       <= (h_nxt >= H_ACTIVE);
            vblnk       <= (v_nxt >= V_ACTIVE);
            hsync       <= (h_nxt >= H_SYNC_START) && (h_nxt < H_SYNC_START + H_SYNC_LEN);
            vsync       <= (v_nxt >= V_SYNC_START) && (v_nxt < V_SYNC_START + V_SYNC_LEN);
            frame_start <= (h_nxt == '0) && (v_nxt == '0);  // first pixel of frame
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
verilator --binary --assert -Wno-fatal --top-module tb_game_display -f sim.f \
    && ./obj_dir/Vtb_game_display | tee /dev/stderr | grep "Simulation PASSED" > /dev/null \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }

/* sim.f */
logic/vga_pkg.sv
logic/screen_pkg.sv
logic/vga_timing.sv
logic/screen_ctrl_wb.sv
logic/start_screen.sv
logic/finish_screen.sv
logic/screen_select.sv
logic/game_display_top.sv
bench/tb_clock.sv
bench/display_checker.sv
bench/tb_game_display.sv
